// ==== compile.f ====
design/lsu_pkg.sv
design/mem_req_if.sv
design/lsu_dispatch.sv
design/lsu_buffer.sv
design/lsu_data_mem.sv
design/lsu_top.sv
tests/lsu_tb.sv

// ==== design/lsu_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_buffer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  clr,
    input  wire                  ent_valid,
    input  wire lsu_pkg::tag_t   ent_tag,
    input  wire                  ent_store,
    input  wire lsu_pkg::width_t ent_width,
    input  wire                  ent_signed,
    input  wire lsu_pkg::data_t  ent_imm,
    input  wire lsu_pkg::tag_t   ent_rs1_tag,
    input  wire lsu_pkg::data_t  ent_rs1_data,
    input  wire lsu_pkg::tag_t   ent_rs2_tag,
    input  wire lsu_pkg::data_t  ent_rs2_data,
    input  wire                  ex_valid,
    input  wire lsu_pkg::tag_t   ex_tag,
    input  wire lsu_pkg::data_t  ex_data,
    input  wire                  commit_valid,
    input  wire lsu_pkg::tag_t   commit_tag,
    output logic                 full,
    mem_req_if.buffer            mem
);
    import lsu_pkg::*;

    // per-slot state, indexed by tag
    logic [NUM_SLOTS-1:0] occ;
    logic [NUM_SLOTS-1:0] issued;
    logic [NUM_SLOTS-1:0] is_store;
    logic [NUM_SLOTS-1:0] sgn;
    logic [NUM_SLOTS-1:0] rs1_ok;
    logic [NUM_SLOTS-1:0] rs2_ok;
    width_t               width    [NUM_SLOTS];
    data_t                imm      [NUM_SLOTS];
    tag_t                 rs1_tag  [NUM_SLOTS];
    tag_t                 rs2_tag  [NUM_SLOTS];
    data_t                rs1_data [NUM_SLOTS];
    data_t                rs2_data [NUM_SLOTS];

    // commit waiting for its store to issue
    logic pend_valid;
    tag_t pend_tag;

    logic st_go;
    logic ld_go;
    tag_t ld_tag;
    tag_t sel_tag;
    logic sel_go;

    // broadcast from execute or from our own load result
    function automatic logic snoop_hit(tag_t t);
        snoop_hit = (t != '0) && ((ex_valid && ex_tag == t) || (mem.rsp_valid && mem.rsp_tag == t));
    endfunction

    function automatic data_t snoop_data(tag_t t);
        snoop_data = (ex_valid && ex_tag == t) ? ex_data : mem.rsp_data;
    endfunction

    assign full = &occ[NUM_SLOTS-1:1];

    // store has priority, then lowest ready load
    always_comb begin
        st_go  = pend_valid && occ[pend_tag] && is_store[pend_tag] && !issued[pend_tag]
                 && rs1_ok[pend_tag] && rs2_ok[pend_tag];
        ld_go  = 1'b0;
        ld_tag = '0;
        for (int i = NUM_SLOTS - 1; i > 0; i--) begin
            if (occ[i] && !is_store[i] && !issued[i] && rs1_ok[i]) begin
                ld_go  = 1'b1;
                ld_tag = tag_t'(i);
            end
        end
        sel_tag = st_go ? pend_tag : ld_tag;
    end

    // request register is free or being drained
    assign sel_go = (st_go || ld_go) && (!mem.req_valid || mem.req_ready);

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            occ           <= '0;
            issued        <= '0;
            pend_valid    <= 1'b0;
            mem.req_valid <= 1'b0;
        end else begin
            // load slot freed by its response
            if (mem.rsp_valid) begin
                occ[mem.rsp_tag] <= 1'b0;
            end
            if (mem.req_valid && mem.req_ready) begin
                mem.req_valid <= 1'b0;
                // store slot freed on accept
                if (mem.req_store) begin
                    occ[mem.req_tag] <= 1'b0;
                end
            end
            if (sel_go) begin
                mem.req_valid   <= 1'b1;
                issued[sel_tag] <= 1'b1;
                if (st_go) begin
                    pend_valid <= 1'b0;
                end
            end
            if (commit_valid) begin
                pend_valid <= 1'b1;
            end
            if (ent_valid) begin
                occ[ent_tag]    <= 1'b1;
                issued[ent_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < NUM_SLOTS; i++) begin
            if (occ[i] && !rs1_ok[i] && snoop_hit(rs1_tag[i])) begin
                rs1_ok[i]   <= 1'b1;
                rs1_data[i] <= snoop_data(rs1_tag[i]);
            end
            if (occ[i] && !rs2_ok[i] && snoop_hit(rs2_tag[i])) begin
                rs2_ok[i]   <= 1'b1;
                rs2_data[i] <= snoop_data(rs2_tag[i]);
            end
        end
        if (sel_go) begin
            mem.req_store  <= st_go;
            mem.req_tag    <= sel_tag;
            mem.req_width  <= width[sel_tag];
            mem.req_signed <= sgn[sel_tag];
            mem.req_addr   <= rs1_data[sel_tag] + imm[sel_tag];
            mem.req_wdata  <= rs2_data[sel_tag];
        end
        if (commit_valid) begin
            pend_tag <= commit_tag;
        end
        // new entry, a same-cycle broadcast also counts
        if (ent_valid) begin
            is_store[ent_tag] <= ent_store;
            sgn[ent_tag]      <= ent_signed;
            width[ent_tag]    <= ent_width;
            imm[ent_tag]      <= ent_imm;
            rs1_tag[ent_tag]  <= ent_rs1_tag;
            rs2_tag[ent_tag]  <= ent_rs2_tag;
            rs1_ok[ent_tag]   <= (ent_rs1_tag == '0) || snoop_hit(ent_rs1_tag);
            rs2_ok[ent_tag]   <= (ent_rs2_tag == '0) || snoop_hit(ent_rs2_tag);
            rs1_data[ent_tag] <= snoop_hit(ent_rs1_tag) ? snoop_data(ent_rs1_tag) : ent_rs1_data;
            rs2_data[ent_tag] <= snoop_hit(ent_rs2_tag) ? snoop_data(ent_rs2_tag) : ent_rs2_data;
        end
    end

    a_disp_free: assert property (@(posedge clk) disable iff (rst || clr)
        ent_valid |-> !occ[ent_tag]);

    // the store may still sit in the dispatch register
    a_commit_store: assert property (@(posedge clk) disable iff (rst || clr)
        commit_valid |-> (occ[commit_tag] && is_store[commit_tag])
                         || (ent_valid && ent_tag == commit_tag && ent_store));

    a_aligned: assert property (@(posedge clk) disable iff (rst || clr)
        mem.req_valid |-> !((mem.req_width == W_HALF && mem.req_addr[0])
                            || (mem.req_width == W_WORD && mem.req_addr[1:0] != 2'b00)));

endmodule

`default_nettype wire

// ==== design/lsu_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_data_mem (
    input  wire            clk,
    input  wire            rst,
    input  wire            clr,
    mem_req_if.memory      mem,
    output logic           cdb_valid,
    output lsu_pkg::tag_t  cdb_tag,
    output lsu_pkg::data_t cdb_data
);
    import lsu_pkg::*;

    data_t                          ram [MEM_WORDS];
    mem_state_t                     state;
    logic [$clog2(MEM_LATENCY)-1:0] cnt;
    logic                           accept;
    word_idx_t                      wr_idx;
    logic [3:0]                     wr_be;
    data_t                          wr_data;
    word_idx_t                      rd_idx;
    logic [1:0]                     rd_off;
    width_t                         rd_width;
    logic                           rd_signed;
    data_t                          rd_word;
    data_t                          shifted;
    data_t                          load_ext;

    // one load in flight at a time
    assign mem.req_ready = (state == MEM_IDLE);
    assign accept        = mem.req_valid && mem.req_ready;
    assign wr_idx        = mem.req_addr[MEM_ADDR_BITS-1:2];

    // byte lanes, little endian
    always_comb begin
        case (mem.req_width)
            W_BYTE: begin
                wr_be   = 4'b0001 << mem.req_addr[1:0];
                wr_data = {4{mem.req_wdata[7:0]}};
            end
            W_HALF: begin
                wr_be   = 4'b0011 << {mem.req_addr[1], 1'b0};
                wr_data = {2{mem.req_wdata[15:0]}};
            end
            default: begin
                wr_be   = 4'b1111;
                wr_data = mem.req_wdata;
            end
        endcase
    end

    always_comb begin
        shifted = rd_word >> {rd_off, 3'b000};
        case (rd_width)
            W_BYTE:  load_ext = {{24{rd_signed && shifted[7]}}, shifted[7:0]};
            W_HALF:  load_ext = {{16{rd_signed && shifted[15]}}, shifted[15:0]};
            default: load_ext = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            state         <= MEM_IDLE;
            cnt           <= '0;
            mem.rsp_valid <= 1'b0;
        end else begin
            mem.rsp_valid <= 1'b0;
            case (state)
                MEM_IDLE: begin
                    if (accept && !mem.req_store) begin
                        state <= MEM_BUSY;
                        cnt   <= $bits(cnt)'(MEM_LATENCY - 1);
                    end
                end
                MEM_BUSY: begin
                    if (cnt == '0) begin
                        state         <= MEM_IDLE;
                        mem.rsp_valid <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem.req_store && !clr) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    ram[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        if (accept && !mem.req_store) begin
            rd_idx      <= wr_idx;
            rd_off      <= mem.req_addr[1:0];
            rd_width    <= mem.req_width;
            rd_signed   <= mem.req_signed;
            mem.rsp_tag <= mem.req_tag;
        end
        if (state == MEM_BUSY) begin
            rd_word <= ram[rd_idx];
        end
        if (state == MEM_BUSY && cnt == '0) begin
            mem.rsp_data <= load_ext;
        end
    end

    // result goes out on cdb with the response
    assign cdb_valid = mem.rsp_valid;
    assign cdb_tag   = mem.rsp_tag;
    assign cdb_data  = mem.rsp_data;

    a_one_load: assert property (@(posedge clk) disable iff (rst || clr)
        accept && !mem.req_store |=> (!accept [*MEM_LATENCY]) ##1 mem.rsp_valid);

endmodule

`default_nettype wire

// ==== design/lsu_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_dispatch (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  clr,
    input  wire                  disp_valid,
    input  wire lsu_pkg::op_t    disp_op,
    input  wire lsu_pkg::tag_t   disp_tag,
    input  wire lsu_pkg::data_t  disp_imm,
    input  wire lsu_pkg::tag_t   rs1_tag,
    input  wire lsu_pkg::data_t  rs1_data,
    input  wire lsu_pkg::tag_t   rs2_tag,
    input  wire lsu_pkg::data_t  rs2_data,
    output logic                 ent_valid,
    output lsu_pkg::tag_t        ent_tag,
    output logic                 ent_store,
    output lsu_pkg::width_t      ent_width,
    output logic                 ent_signed,
    output lsu_pkg::data_t       ent_imm,
    output lsu_pkg::tag_t        ent_rs1_tag,
    output lsu_pkg::data_t       ent_rs1_data,
    output lsu_pkg::tag_t        ent_rs2_tag,
    output lsu_pkg::data_t       ent_rs2_data
);
    import lsu_pkg::*;

    logic   dec_ok;
    logic   dec_store;
    width_t dec_width;
    logic   dec_signed;

    // opcode to direction, size and sign
    always_comb begin
        dec_ok     = 1'b1;
        dec_store  = 1'b0;
        dec_width  = W_WORD;
        dec_signed = 1'b0;
        case (disp_op)
            OP_LB: begin
                dec_width  = W_BYTE;
                dec_signed = 1'b1;
            end
            OP_LH: begin
                dec_width  = W_HALF;
                dec_signed = 1'b1;
            end
            OP_LW:  dec_width = W_WORD;
            OP_LBU: dec_width = W_BYTE;
            OP_LHU: dec_width = W_HALF;
            OP_SB: begin
                dec_store = 1'b1;
                dec_width = W_BYTE;
            end
            OP_SH: begin
                dec_store = 1'b1;
                dec_width = W_HALF;
            end
            OP_SW:   dec_store = 1'b1;
            default: dec_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            ent_valid <= 1'b0;
        end else begin
            ent_valid <= disp_valid && dec_ok;
        end
    end

    always_ff @(posedge clk) begin
        ent_tag      <= disp_tag;
        ent_store    <= dec_store;
        ent_width    <= dec_width;
        ent_signed   <= dec_signed;
        ent_imm      <= disp_imm;
        ent_rs1_tag  <= rs1_tag;
        ent_rs1_data <= rs1_data;
        // loads have no second operand
        ent_rs2_tag  <= dec_store ? rs2_tag : '0;
        ent_rs2_data <= rs2_data;
    end

endmodule

`default_nettype wire

// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // rename tag, 0 means no producer and the operand is already valid
    typedef logic [3:0]  tag_t;
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [2:0]  op_t;
    typedef logic [1:0]  width_t;

    // memory opcodes
    localparam op_t OP_LB  = 3'b000;
    localparam op_t OP_LH  = 3'b001;
    localparam op_t OP_LW  = 3'b010;
    localparam op_t OP_SB  = 3'b011;
    localparam op_t OP_LBU = 3'b100;
    localparam op_t OP_LHU = 3'b101;
    localparam op_t OP_SH  = 3'b110;
    localparam op_t OP_SW  = 3'b111;

    // access size
    localparam width_t W_BYTE = 2'd0;
    localparam width_t W_HALF = 2'd1;
    localparam width_t W_WORD = 2'd2;

    // one slot per tag, slot 0 unused
    localparam int NUM_SLOTS = 16;

    // 1 KiB data memory, upper address bits ignored
    localparam int MEM_ADDR_BITS = 10;
    localparam int MEM_WORDS     = 2 ** (MEM_ADDR_BITS - 2);

    // accepted load request to response
    localparam int MEM_LATENCY = 2;

    typedef logic [MEM_ADDR_BITS-3:0] word_idx_t;

    typedef enum logic {
        MEM_IDLE,
        MEM_BUSY
    } mem_state_t;

endpackage

`default_nettype wire

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 clr,
    input  wire                 disp_valid,
    input  wire lsu_pkg::op_t   disp_op,
    input  wire lsu_pkg::tag_t  disp_tag,
    input  wire lsu_pkg::data_t disp_imm,
    input  wire lsu_pkg::tag_t  rs1_tag,
    input  wire lsu_pkg::data_t rs1_data,
    input  wire lsu_pkg::tag_t  rs2_tag,
    input  wire lsu_pkg::data_t rs2_data,
    input  wire                 ex_valid,
    input  wire lsu_pkg::tag_t  ex_tag,
    input  wire lsu_pkg::data_t ex_data,
    input  wire                 commit_valid,
    input  wire lsu_pkg::tag_t  commit_tag,
    output logic                full,
    output logic                cdb_valid,
    output lsu_pkg::tag_t       cdb_tag,
    output lsu_pkg::data_t      cdb_data
);
    import lsu_pkg::*;

    // registered entry from dispatch
    logic   ent_valid;
    tag_t   ent_tag;
    logic   ent_store;
    width_t ent_width;
    logic   ent_signed;
    data_t  ent_imm;
    tag_t   ent_rs1_tag;
    data_t  ent_rs1_data;
    tag_t   ent_rs2_tag;
    data_t  ent_rs2_data;

    mem_req_if mem_bus ();

    lsu_dispatch u_dispatch (
        .clk, .rst, .clr,
        .disp_valid, .disp_op, .disp_tag, .disp_imm,
        .rs1_tag, .rs1_data, .rs2_tag, .rs2_data,
        .ent_valid, .ent_tag, .ent_store, .ent_width, .ent_signed, .ent_imm,
        .ent_rs1_tag, .ent_rs1_data, .ent_rs2_tag, .ent_rs2_data
    );

    lsu_buffer u_buffer (
        .clk, .rst, .clr,
        .ent_valid, .ent_tag, .ent_store, .ent_width, .ent_signed, .ent_imm,
        .ent_rs1_tag, .ent_rs1_data, .ent_rs2_tag, .ent_rs2_data,
        .ex_valid, .ex_tag, .ex_data,
        .commit_valid, .commit_tag,
        .full,
        .mem (mem_bus.buffer)
    );

    lsu_data_mem u_data_mem (
        .clk, .rst, .clr,
        .mem (mem_bus.memory),
        .cdb_valid, .cdb_tag, .cdb_data
    );

endmodule

`default_nettype wire

// ==== design/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
    import lsu_pkg::*;

    // request, held steady while valid and not ready
    logic   req_valid;
    logic   req_ready;
    logic   req_store;
    tag_t   req_tag;
    width_t req_width;
    logic   req_signed;
    addr_t  req_addr;
    data_t  req_wdata;

    // one-cycle response strobe
    logic   rsp_valid;
    tag_t   rsp_tag;
    data_t  rsp_data;

    modport buffer (
        output req_valid, req_store, req_tag, req_width, req_signed, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_tag, rsp_data
    );

    modport memory (
        input  req_valid, req_store, req_tag, req_width, req_signed, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_tag, rsp_data
    );

endinterface

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the lsu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lsu_tb -f compile.f -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int STORE_SETTLE = 8;

    logic  clk;
    logic  rst;
    logic  clr;
    logic  disp_valid;
    op_t   disp_op;
    tag_t  disp_tag;
    data_t disp_imm;
    tag_t  rs1_tag;
    data_t rs1_data;
    tag_t  rs2_tag;
    data_t rs2_data;
    logic  ex_valid;
    tag_t  ex_tag;
    data_t ex_data;
    logic  commit_valid;
    tag_t  commit_tag;
    logic  full;
    logic  cdb_valid;
    tag_t  cdb_tag;
    data_t cdb_data;

    // byte model of data memory updated on each committed store
    logic [7:0]  model [1024];
    data_t       exp_data [16];
    int          sent_cnt [16] = '{default: 0};
    int          seen_cnt [16] = '{default: 0};
    logic        hold_cdb;
    logic [31:0] rng;
    int          mon_errors = 0;
    int          quiet_errors = 0;
    int          clr_errors = 0;
    int          chk_errors = 0;
    int          errors_before = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;

    lsu_top dut_i (
        .clk, .rst, .clr,
        .disp_valid, .disp_op, .disp_tag, .disp_imm,
        .rs1_tag, .rs1_data, .rs2_tag, .rs2_data,
        .ex_valid, .ex_tag, .ex_data,
        .commit_valid, .commit_tag,
        .full, .cdb_valid, .cdb_tag, .cdb_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES + 200 * NUM_TESTS) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 RESET_CYCLES + 200 * NUM_TESTS);
        $display("Some tests failed");
        $finish;
    end

    // every cdb result must match an outstanding load of that tag
    always @(posedge clk) begin
        if (!rst && cdb_valid) begin
            if (seen_cnt[cdb_tag] >= sent_cnt[cdb_tag]) begin
                $display("unexpected cdb result for tag %0d at %0t", cdb_tag, $time);
                mon_errors++;
            end else begin
                assert (cdb_data == exp_data[cdb_tag]) else begin
                    $display("** Error: cdb_data for tag %0d expected %h got %h",
                             cdb_tag, exp_data[cdb_tag], cdb_data);
                    mon_errors++;
                end
                seen_cnt[cdb_tag]++;
            end
        end
    end

    a_quiet_cdb: assert property (@(posedge clk) disable iff (rst) hold_cdb |-> !cdb_valid)
    else begin
        $display("cdb result appeared while no load was allowed to finish");
        quiet_errors++;
    end

    a_clr_empties: assert property (@(posedge clk) disable iff (rst) clr |=> !full && !cdb_valid)
    else begin
        $display("full or cdb_valid still high the cycle after clr");
        clr_errors++;
    end

    function automatic int total_errors();
        return mon_errors + quiet_errors + clr_errors + chk_errors;
    endfunction

    // xorshift32
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic op_t pick_load_op(logic [2:0] sel);
        case (sel)
            3'd0:    return OP_LB;
            3'd1:    return OP_LH;
            3'd2:    return OP_LW;
            3'd3:    return OP_LBU;
            default: return OP_LHU;
        endcase
    endfunction

    // little endian bytes extended per load opcode
    function automatic data_t expect_load(op_t op, addr_t addr);
        logic [9:0] i;
        logic [7:0] b0, b1, b2, b3;
        i  = addr[9:0];
        b0 = model[i];
        b1 = model[i + 10'd1];
        b2 = model[i + 10'd2];
        b3 = model[i + 10'd3];
        case (op)
            OP_LB:   return {{24{b0[7]}}, b0};
            OP_LBU:  return {24'h0, b0};
            OP_LH:   return {{16{b1[7]}}, b1, b0};
            OP_LHU:  return {16'h0, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic void update_model(op_t op, addr_t addr, data_t data);
        logic [9:0] i;
        i = addr[9:0];
        model[i] = data[7:0];
        if (op != OP_SB) begin
            model[i + 10'd1] = data[15:8];
        end
        if (op == OP_SW) begin
            model[i + 10'd2] = data[23:16];
            model[i + 10'd3] = data[31:24];
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("check failed at %0t: %s", $time, what);
            chk_errors++;
        end
    endtask

    task automatic dispatch_op(op_t op, tag_t tag, data_t imm, tag_t t1, data_t d1,
                               tag_t t2, data_t d2);
        disp_valid = 1'b1;
        disp_op    = op;
        disp_tag   = tag;
        disp_imm   = imm;
        rs1_tag    = t1;
        rs1_data   = d1;
        rs2_tag    = t2;
        rs2_data   = d2;
        next_cycle();
        disp_valid = 1'b0;
    endtask

    task automatic commit_store(tag_t tag);
        commit_valid = 1'b1;
        commit_tag   = tag;
        next_cycle();
        commit_valid = 1'b0;
    endtask

    task automatic ex_broadcast(tag_t tag, data_t data);
        ex_valid = 1'b1;
        ex_tag   = tag;
        ex_data  = data;
        next_cycle();
        ex_valid = 1'b0;
    endtask

    task automatic wait_done(tag_t tag);
        while (seen_cnt[tag] < sent_cnt[tag]) begin
            next_cycle();
        end
    endtask

    task automatic wait_all();
        for (int t = 1; t < 16; t++) begin
            wait_done(tag_t'(t));
        end
    endtask

    // base is the value the producer will deliver when base_tag is nonzero
    task automatic start_load(op_t op, tag_t tag, tag_t base_tag, addr_t base, data_t imm);
        exp_data[tag] = expect_load(op, base + imm);
        sent_cnt[tag]++;
        dispatch_op(op, tag, imm, base_tag, (base_tag == 4'd0) ? base : 32'h0, 4'd0, 32'h0);
    endtask

    task automatic run_store(op_t op, tag_t tag, addr_t addr, data_t data);
        wait_all();
        dispatch_op(op, tag, 32'h10, 4'd0, addr - 32'h10, 4'd0, data);
        commit_store(tag);
        repeat (STORE_SETTLE) next_cycle();
        update_model(op, addr, data);
    endtask

    task automatic report_test(string name);
        int cur;
        cur = total_errors();
        if (cur == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: FAILED with %0d errors", name, cur - errors_before);
        end
        errors_before = cur;
    endtask

    task automatic store_load_widths();
        run_store(OP_SW, 4'd12, 32'h100, next_random() | 32'h8000_0080);
        run_store(OP_SH, 4'd12, 32'h104, next_random() & 32'hffff_7fff);
        run_store(OP_SH, 4'd12, 32'h106, next_random() | 32'h0000_8000);
        run_store(OP_SB, 4'd12, 32'h108, next_random());
        run_store(OP_SB, 4'd12, 32'h109, next_random() & 32'hffff_ff7f);
        run_store(OP_SB, 4'd12, 32'h10a, next_random());
        run_store(OP_SB, 4'd12, 32'h10b, next_random() | 32'h0000_0080);
        // several loads in flight at once
        start_load(OP_LW,  4'd1, 4'd0, 32'h100, 32'h0);
        start_load(OP_LW,  4'd2, 4'd0, 32'h0f0, 32'h14);
        start_load(OP_LW,  4'd3, 4'd0, 32'h10c, 32'hffff_fffc);
        start_load(OP_LH,  4'd4, 4'd0, 32'h106, 32'h0);
        start_load(OP_LHU, 4'd5, 4'd0, 32'h106, 32'h0);
        start_load(OP_LH,  4'd6, 4'd0, 32'h104, 32'h0);
        start_load(OP_LB,  4'd7, 4'd0, 32'h10b, 32'h0);
        start_load(OP_LBU, 4'd8, 4'd0, 32'h10b, 32'h0);
        start_load(OP_LB,  4'd9, 4'd0, 32'h109, 32'h0);
        start_load(OP_LB,  4'd10, 4'd0, 32'h100, 32'h0);
        start_load(OP_LHU, 4'd11, 4'd0, 32'h102, 32'h0);
        wait_all();
        report_test("store_load_widths");
    endtask

    task automatic ex_wakeup();
        data_t new_val;
        run_store(OP_SW, 4'd12, 32'h1c0, next_random());
        run_store(OP_SW, 4'd12, 32'h1c4, next_random());
        new_val  = next_random();
        hold_cdb = 1'b1;
        start_load(OP_LW, 4'd1, 4'd14, 32'h1c0, 32'h4);
        dispatch_op(OP_SW, 4'd2, 32'h0, 4'd13, 32'h0, 4'd12, 32'h0);
        repeat (10) next_cycle();
        hold_cdb = 1'b0;
        ex_broadcast(4'd14, 32'h1c0);
        wait_done(4'd1);
        ex_broadcast(4'd13, 32'h1c0);
        ex_broadcast(4'd12, new_val);
        repeat (4) next_cycle();
        // operands known but no commit yet
        start_load(OP_LW, 4'd3, 4'd0, 32'h1c0, 32'h0);
        wait_done(4'd3);
        commit_store(4'd2);
        repeat (STORE_SETTLE) next_cycle();
        update_model(OP_SW, 32'h1c0, new_val);
        start_load(OP_LW, 4'd4, 4'd0, 32'h1c0, 32'h0);
        wait_done(4'd4);
        report_test("ex_wakeup");
    endtask

    task automatic cdb_wakeup();
        run_store(OP_SW, 4'd12, 32'h180, 32'h0000_0240);
        run_store(OP_SW, 4'd12, 32'h248, next_random());
        start_load(OP_LW, 4'd1, 4'd0, 32'h180, 32'h0);
        start_load(OP_LW, 4'd2, 4'd1, 32'h240, 32'h8);
        wait_done(4'd1);
        check_true(seen_cnt[2] < sent_cnt[2], "dependent load finished before its producer");
        wait_done(4'd2);
        report_test("cdb_wakeup");
    endtask

    task automatic commit_gating();
        data_t new_val;
        run_store(OP_SW, 4'd12, 32'h1c8, next_random());
        new_val = next_random();
        dispatch_op(OP_SH, 4'd5, 32'h2, 4'd0, 32'h1c8, 4'd0, new_val);
        repeat (8) next_cycle();
        start_load(OP_LW, 4'd6, 4'd0, 32'h1c8, 32'h0);
        wait_done(4'd6);
        commit_store(4'd5);
        repeat (STORE_SETTLE) next_cycle();
        update_model(OP_SH, 32'h1ca, new_val);
        start_load(OP_LW, 4'd7, 4'd0, 32'h1c8, 32'h0);
        wait_done(4'd7);
        report_test("commit_gating");
    endtask

    task automatic full_flush();
        hold_cdb = 1'b1;
        // base tag 15 never broadcasts
        for (int t = 1; t < 16; t++) begin
            dispatch_op(OP_LW, tag_t'(t), 32'h0, 4'd15, 32'h0, 4'd0, 32'h0);
        end
        next_cycle();
        check_true(full, "full is low with every slot in use");
        clr = 1'b1;
        next_cycle();
        clr = 1'b0;
        check_true(!full, "full still high after clr");
        repeat (10) next_cycle();
        hold_cdb = 1'b0;
        start_load(OP_LW, 4'd3, 4'd0, 32'h100, 32'h0);
        wait_done(4'd3);
        report_test("full_flush");
    endtask

    task automatic random_mix();
        logic [31:0] r;
        addr_t       a;
        data_t       imm;
        op_t         op;
        tag_t        tag;
        tag = 4'd1;
        // every word a random load can reach
        for (int w = 0; w < 16; w++) begin
            run_store(OP_SW, 4'd15, 32'h200 + 32'(4 * w), next_random());
        end
        for (int n = 0; n < 16; n++) begin
            r   = next_random();
            a   = 32'h200 + {26'h0, r[5:4], 4'h0} + {28'h0, r[13:12], 2'b00};
            imm = {28'h0, r[11:8]} - 32'd8;
            if (r[0]) begin
                op = r[1] ? OP_SW : (r[2] ? OP_SH : OP_SB);
                if (op == OP_SH) a = a + {30'h0, r[6], 1'b0};
                if (op == OP_SB) a = a + {30'h0, r[7:6]};
                run_store(op, 4'd15, a, next_random());
            end else begin
                op = pick_load_op(r[3:1]);
                if (op == OP_LH || op == OP_LHU) a = a + {30'h0, r[6], 1'b0};
                if (op == OP_LB || op == OP_LBU) a = a + {30'h0, r[7:6]};
                wait_done(tag);
                start_load(op, tag, 4'd0, a - imm, imm);
                tag = (tag == 4'd14) ? 4'd1 : tag + 4'd1;
            end
        end
        wait_all();
        report_test("random_mix");
    endtask

    initial begin
        rng          = 32'h48c4;
        rst          = 1'b1;
        clr          = 1'b0;
        disp_valid   = 1'b0;
        disp_op      = OP_LW;
        disp_tag     = 4'd0;
        disp_imm     = 32'h0;
        rs1_tag      = 4'd0;
        rs1_data     = 32'h0;
        rs2_tag      = 4'd0;
        rs2_data     = 32'h0;
        ex_valid     = 1'b0;
        ex_tag       = 4'd0;
        ex_data      = 32'h0;
        commit_valid = 1'b0;
        commit_tag   = 4'd0;
        hold_cdb     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        store_load_widths();
        ex_wakeup();
        cdb_wakeup();
        commit_gating();
        full_flush();
        random_mix();
        $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, total_errors());
        if (tests_bad == 0 && total_errors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
